// File: Bender.yml
package:
  name: msx_cart_rom

sources:
  - source/msx_cart_pkg.sv
  - source/cart_mapper_decoder.sv
  - source/cart_konami.sv
  - source/cart_ascii8.sv
  - source/cart_ascii16.sv
  - source/cart_linear.sv
  - source/cart_mem_arbiter.sv
  - source/cart_rom.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/cart_rom_tb.sv

// File: source/cart_ascii16.sv
// ASCII-16 mapper with two 16 kB pages and 2 kB battery SRAM
module cart_ascii16
    import msx_cart_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_en,
    input  logic      cs,
    input  cpu_bus_t  bus,
    input  cart_cfg_t cfg,
    output mem_req_t  req
);

    logic [7:0] bank [2];
    logic       half;
    logic       in_range;
    logic       reg_wr;
    logic [7:0] cur_bank;
    logic [7:0] bank_8k;
    logic       is_sram;
    logic       sram_oe;
    logic       sram_we;

    assign half     = bus.addr[15];                  // 0 for 4000-7FFF, 1 for 8000-BFFF
    assign in_range = bus.addr[15] ^ bus.addr[14];
    assign reg_wr   = clk_en & cs & bus.wr & bus.mreq;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank[0] <= 8'd0;
            bank[1] <= 8'd0;
        end else if (reg_wr) begin
            case (bus.addr[15:11])
                5'b01100: bank[0] <= bus.data;       // 6000-67FF
                5'b01110: bank[1] <= bus.data;       // 7000-77FF
                default: ;
            endcase
        end
    end

    assign cur_bank = bank[half];
    assign bank_8k  = {cur_bank[6:0], bus.addr[13]}; // 16 kB bank as two 8 kB halves
    assign is_sram  = cur_bank[ASCII16_SRAM_BIT];

    assign sram_oe = cs & in_range & is_sram & bus.rd;
    assign sram_we = cs & in_range & is_sram & half & bus.wr;

    always_comb begin
        if (is_sram) begin
            req.addr = SRAM_BASE + MEM_AW'(bus.addr[10:0]);
        end else begin
            req.addr = rom_addr_8k(bank_8k, cfg.rom_size_log, bus.addr[12:0]);
        end
        req.valid   = (cs & in_range & bus.rd) | sram_we;
        req.sram_oe = sram_oe;
        req.sram_we = sram_we;
    end

endmodule

// File: source/cart_ascii8.sv
// ASCII-8 mapper with four 8 kB pages and battery SRAM on the upper pages
module cart_ascii8
    import msx_cart_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_en,
    input  logic      cs,
    input  cpu_bus_t  bus,
    input  cart_cfg_t cfg,
    output mem_req_t  req
);

    logic [7:0] bank [4];
    logic [1:0] page;
    logic       in_range;
    logic       reg_window;
    logic       reg_wr;
    logic [7:0] cur_bank;
    logic       is_sram;
    logic       sram_oe;
    logic       sram_we;

    assign page       = {bus.addr[15], bus.addr[13]};
    assign in_range   = bus.addr[15] ^ bus.addr[14];
    assign reg_window = bus.addr[15:13] == 3'b011;   // 6000-7FFF, 2 kB per register
    assign reg_wr     = clk_en & cs & bus.wr & bus.mreq & reg_window;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= 8'd0;
            end
        end else if (reg_wr) begin
            bank[bus.addr[12:11]] <= bus.data;
        end
    end

    assign cur_bank = bank[page];
    assign is_sram  = cur_bank[ASCII8_SRAM_BIT];

    // SRAM is writable only in 8000-BFFF
    assign sram_oe = cs & in_range & is_sram & bus.rd;
    assign sram_we = cs & in_range & is_sram & page[1] & bus.wr;

    always_comb begin
        if (is_sram) begin
            req.addr = SRAM_BASE + MEM_AW'(bus.addr[12:0]);
        end else begin
            req.addr = rom_addr_8k(cur_bank, cfg.rom_size_log, bus.addr[12:0]);
        end
        req.valid   = (cs & in_range & bus.rd) | sram_we;
        req.sram_oe = sram_oe;
        req.sram_we = sram_we;
    end

endmodule

// File: source/cart_konami.sv
// Konami mapper without SCC, three switchable 8 kB pages and a fixed first page
module cart_konami
    import msx_cart_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_en,
    input  logic      cs,
    input  cpu_bus_t  bus,
    input  cart_cfg_t cfg,
    output mem_req_t  req
);

    logic [7:0] bank [1:3];
    logic [1:0] page;
    logic       in_range;
    logic       reg_wr;
    logic [7:0] cur_bank;

    assign page     = {bus.addr[15], bus.addr[13]}; // 4000/6000/8000/A000 -> 0..3
    assign in_range = bus.addr[15] ^ bus.addr[14];   // 4000-BFFF
    assign reg_wr   = clk_en & cs & bus.wr & bus.mreq & in_range;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank[1] <= 8'd1;
            bank[2] <= 8'd2;
            bank[3] <= 8'd3;
        end else if (reg_wr) begin
            case (page)
                2'd1: bank[1] <= bus.data;
                2'd2: bank[2] <= bus.data;
                2'd3: bank[3] <= bus.data;
                default: ;                           // Page 0 is fixed
            endcase
        end
    end

    always_comb begin
        case (page)
            2'd1:    cur_bank = bank[1];
            2'd2:    cur_bank = bank[2];
            2'd3:    cur_bank = bank[3];
            default: cur_bank = 8'd0;
        endcase
    end

    always_comb begin
        req.addr    = rom_addr_8k(cur_bank, cfg.rom_size_log, bus.addr[12:0]);
        req.valid   = cs & in_range & bus.rd;
        req.sram_oe = 1'b0;
        req.sram_we = 1'b0;
    end

endmodule

// File: source/cart_linear.sv
// Plain ROM without banking, placed by size and mirrored inside its window
module cart_linear
    import msx_cart_pkg::*;
(
    input  logic      cs,
    input  cpu_bus_t  bus,
    input  cart_cfg_t cfg,
    output mem_req_t  req
);

    logic        low_base;
    logic        in_window;
    logic [15:0] offset;
    logic [20:0] offs_mask;

    assign low_base  = cfg.rom_size_log >= 4'd3;     // 64 kB image starts at 0000
    assign in_window = low_base | (bus.addr[15] ^ bus.addr[14]);
    assign offset    = low_base ? bus.addr : bus.addr - 16'h4000;
    assign offs_mask = {bank_mask(cfg.rom_size_log), 13'h1FFF};

    always_comb begin
        req.addr    = MEM_AW'({5'd0, offset} & offs_mask); // Smaller images mirror
        req.valid   = cs & in_window & bus.rd;
        req.sram_oe = 1'b0;
        req.sram_we = 1'b0;
    end

endmodule

// File: source/cart_mapper_decoder.sv
// Mapper decoder turning the cartridge configuration into one-hot mapper selects
module cart_mapper_decoder
    import msx_cart_pkg::*;
(
    input  logic        en,
    input  cart_cfg_t   cfg,
    input  cpu_bus_t    bus,
    output mapper_sel_t sel
);

    logic active;

    assign active = en & bus.mreq; // Slot enabled and memory cycle

    always_comb begin
        sel = '0;
        if (active) begin
            case (cfg.mapper)
                MAPPER_LINEAR: begin
                    sel.linear = 1'b1;
                end
                MAPPER_KONAMI: begin
                    sel.konami = 1'b1;
                end
                MAPPER_ASCII8: begin
                    sel.ascii8 = 1'b1;
                end
                MAPPER_ASCII16: begin
                    sel.ascii16 = 1'b1;
                end
                default: begin
                    sel = '0;
                end
            endcase
        end
    end

endmodule

// File: source/cart_mem_arbiter.sv
// Memory arbiter choosing one mapper request, SRAM first and then fixed ROM priority
module cart_mem_arbiter
    import msx_cart_pkg::*;
(
    input  mem_req_t          konami_req,
    input  mem_req_t          ascii8_req,
    input  mem_req_t          ascii16_req,
    input  mem_req_t          linear_req,
    output logic [MEM_AW-1:0] mem_addr,
    output logic              mem_rd,
    output logic              sram_oe,
    output logic              sram_we
);

    mem_req_t reqs [4];
    mem_req_t win;

    // Index 0 has the highest priority
    assign reqs[0] = konami_req;
    assign reqs[1] = ascii8_req;
    assign reqs[2] = ascii16_req;
    assign reqs[3] = linear_req;

    always_comb begin
        win = '0;
        for (int i = 3; i >= 0; i--) begin
            if (reqs[i].valid) begin
                win = reqs[i];
            end
        end
        for (int i = 3; i >= 0; i--) begin
            if (reqs[i].sram_oe | reqs[i].sram_we) begin
                win = reqs[i];               // SRAM overrides any ROM read
            end
        end
    end

    assign mem_addr = win.addr;
    assign mem_rd   = win.valid & ~win.sram_oe & ~win.sram_we;
    assign sram_oe  = win.sram_oe;
    assign sram_we  = win.sram_we;

endmodule

// File: source/cart_rom.sv
// Cartridge slot top level wiring the mapper decoder, the mappers and the memory arbiter
module cart_rom
    import msx_cart_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              clk_en,
    input  logic              en,
    input  logic              wr,
    input  logic              rd,
    input  logic              mreq,
    input  logic [15:0]       addr,
    input  logic [7:0]        d_from_cpu,
    input  cart_cfg_t         cfg,
    output logic [MEM_AW-1:0] mem_addr,
    output logic              mem_rd,
    output logic              sram_oe,
    output logic              sram_we
);

    cpu_bus_t    bus;
    mapper_sel_t sel;
    mem_req_t    konami_req;
    mem_req_t    ascii8_req;
    mem_req_t    ascii16_req;
    mem_req_t    linear_req;

    assign bus = '{addr: addr, data: d_from_cpu, wr: wr, rd: rd, mreq: mreq};

    cart_mapper_decoder decoder (
        .en  (en),
        .cfg (cfg),
        .bus (bus),
        .sel (sel)
    );

    cart_konami konami (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .cs     (sel.konami),
        .bus    (bus),
        .cfg    (cfg),
        .req    (konami_req)
    );

    cart_ascii8 ascii8 (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .cs     (sel.ascii8),
        .bus    (bus),
        .cfg    (cfg),
        .req    (ascii8_req)
    );

    cart_ascii16 ascii16 (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .cs     (sel.ascii16),
        .bus    (bus),
        .cfg    (cfg),
        .req    (ascii16_req)
    );

    cart_linear linear (
        .cs  (sel.linear),
        .bus (bus),
        .cfg (cfg),
        .req (linear_req)
    );

    cart_mem_arbiter arbiter (
        .konami_req  (konami_req),
        .ascii8_req  (ascii8_req),
        .ascii16_req (ascii16_req),
        .linear_req  (linear_req),
        .mem_addr    (mem_addr),
        .mem_rd      (mem_rd),
        .sram_oe     (sram_oe),
        .sram_we     (sram_we)
    );

endmodule

// File: source/msx_cart_pkg.sv
// MSX cartridge mapper package with mapper codes, memory layout and shared bus types
package msx_cart_pkg;

    localparam int MEM_AW           = 25;
    localparam int ASCII8_SRAM_BIT  = 7;
    localparam int ASCII16_SRAM_BIT = 4;

    localparam logic [MEM_AW-1:0] SRAM_BASE = 25'h1F0000; // Battery SRAM region

    typedef enum logic [1:0] {
        MAPPER_LINEAR,
        MAPPER_KONAMI,
        MAPPER_ASCII8,
        MAPPER_ASCII16
    } mapper_t;

    typedef struct packed {
        mapper_t    mapper;
        logic [3:0] rom_size_log; // log2 of size in 8 kB banks
    } cart_cfg_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        wr;
        logic        rd;
        logic        mreq;
    } cpu_bus_t;

    typedef struct packed {
        logic linear;
        logic konami;
        logic ascii8;
        logic ascii16;
    } mapper_sel_t;

    typedef struct packed {
        logic [MEM_AW-1:0] addr;
        logic              valid;
        logic              sram_oe;
        logic              sram_we;
    } mem_req_t;

    // Low size_log bits set, saturates at 8 bits
    function automatic logic [7:0] bank_mask(input logic [3:0] size_log);
        logic [8:0] full;
        full = (9'd1 << size_log) - 9'd1;
        return full[7:0];
    endfunction

    function automatic logic [MEM_AW-1:0] rom_addr_8k(
        input logic [7:0]  bank,
        input logic [3:0]  size_log,
        input logic [12:0] offs
    );
        return MEM_AW'({bank & bank_mask(size_log), offs});
    endfunction

endpackage

// File: verif/cart_model.svh
// Reference model of the cartridge bank registers and the expected memory outputs
`ifndef CART_MODEL_SVH
`define CART_MODEL_SVH

typedef struct packed {
    logic        en;
    logic        clk_en;
    logic        mreq;
    logic        rd;
    logic        wr;
    logic [15:0] addr;
    logic [7:0]  data;
} stim_t;

typedef struct packed {
    logic [MEM_AW-1:0] addr;
    logic              rd;
    logic              oe;
    logic              we;
} mem_out_t;

logic [7:0] konami_bank [4];   // Entry 0 never written
logic [7:0] ascii8_bank [4];
logic [7:0] ascii16_bank [2];

function automatic void reset_model_banks();
    konami_bank  = '{8'd0, 8'd1, 8'd2, 8'd3};
    ascii8_bank  = '{default: 8'd0};
    ascii16_bank = '{default: 8'd0};
endfunction

// Bank number wraps at the image size
function automatic logic [MEM_AW-1:0] rom_location(input int bank, input int size_log,
                                                   input int a);
    return MEM_AW'((bank % (1 << size_log)) * 'h2000 + a % 'h2000);
endfunction

function automatic void update_model_banks(input cart_cfg_t c, input stim_t s);
    int a;
    a = int'(s.addr);
    if (s.en && s.mreq && s.wr && s.clk_en) begin
        if (c.mapper == MAPPER_KONAMI && a >= 'h6000 && a < 'hC000) begin
            konami_bank[(a - 'h4000) / 'h2000] = s.data;
        end else if (c.mapper == MAPPER_ASCII8 && a >= 'h6000 && a < 'h8000) begin
            ascii8_bank[(a - 'h6000) / 'h800] = s.data;    // 2 kB windows
        end else if (c.mapper == MAPPER_ASCII16 && a >= 'h6000 && a < 'h6800) begin
            ascii16_bank[0] = s.data;
        end else if (c.mapper == MAPPER_ASCII16 && a >= 'h7000 && a < 'h7800) begin
            ascii16_bank[1] = s.data;
        end
    end
endfunction

function automatic mem_out_t expected_outputs(input cart_cfg_t c, input stim_t s);
    mem_out_t e;
    int       a;
    int       page;
    int       size_log;
    int       bank8k;
    int       sram_offs;
    logic     sram;
    e         = '0;
    a         = int'(s.addr);
    size_log  = int'(c.rom_size_log);
    page      = (a >= 'h4000 && a < 'hC000) ? (a - 'h4000) / 'h2000 : -1;
    sram      = 1'b0;
    sram_offs = a % 'h2000;
    if (!(s.en && s.mreq)) begin
        return e;
    end
    if (c.mapper == MAPPER_LINEAR) begin
        if (s.rd && (size_log >= 3 || page >= 0)) begin
            e.addr = MEM_AW'((size_log >= 3 ? a : a - 'h4000) % ('h2000 << size_log));
            e.rd   = 1'b1;
        end
        return e;
    end
    if (page < 0) begin
        return e;                                  // Banked mappers serve 4000-BFFF
    end
    case (c.mapper)
        MAPPER_ASCII8: begin
            sram   = ascii8_bank[page][ASCII8_SRAM_BIT];
            bank8k = ascii8_bank[page];
        end
        MAPPER_ASCII16: begin
            sram      = ascii16_bank[page / 2][ASCII16_SRAM_BIT];
            sram_offs = a % 'h800;                 // 2 kB SRAM
            bank8k    = ascii16_bank[page / 2] * 2 + page % 2;
        end
        default: begin
            bank8k = konami_bank[page];
        end
    endcase
    if (sram) begin
        e.oe = s.rd;
        e.we = s.wr && page >= 2;                  // Writable in 8000-BFFF only
        if (e.oe || e.we) begin
            e.addr = SRAM_BASE + MEM_AW'(sram_offs);
        end
    end else if (s.rd) begin
        e.addr = rom_location(bank8k, size_log, a);
        e.rd   = 1'b1;
    end
    return e;
endfunction

`endif

// File: verif/cart_rom_tb.sv
// Testbench for the cartridge slot mapper with random CPU traffic checked against a model
module cart_rom_tb
    import msx_cart_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 8;
    localparam int BLOCK_LEN     = 40;
    // Reset reads, three banked mappers in three blocks, linear sizes, gated accesses
    localparam int TEST_CYCLES   = 32 + 9 * BLOCK_LEN + 64 + 96;
    localparam int WATCHDOG_TIME = (TEST_CYCLES + RESET_CYCLES + 100) * CLK_PERIOD;

    logic              clk;
    logic              reset;
    logic              clk_en;
    logic              en;
    logic              wr;
    logic              rd;
    logic              mreq;
    logic [15:0]       addr;
    logic [7:0]        d_from_cpu;
    cart_cfg_t         cfg;
    logic [MEM_AW-1:0] mem_addr;
    logic              mem_rd;
    logic              sram_oe;
    logic              sram_we;

    integer            seed;
    cart_cfg_t         cur_cfg;
    int                test_num;
    int                test_errors;
    int                test_cycles;
    int                pass_count;
    int                fail_count;

    `include "cart_model.svh"

    cart_rom UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic stim_t bus_op(input logic is_wr, input int lo, input int hi);
        stim_t s;
        s = '{en: 1'b1, clk_en: 1'b1, mreq: 1'b1, rd: !is_wr, wr: is_wr,
              addr: 16'(lo + rand_below(hi - lo + 1)), data: 8'(rand_below(256))};
        return s;
    endfunction

    function automatic stim_t reg_write(input mapper_t m);
        stim_t s;
        case (m)
            MAPPER_ASCII8: begin
                s = bus_op(1'b1, 'h6000, 'h7FFF);
            end
            MAPPER_ASCII16: begin
                s = bus_op(1'b1, 'h6000, 'h67FF);
                s.addr[12] = rand_below(2);        // 6000 or 7000 window
                s.data = (s.data & 8'h6F) | (rand_below(4) == 0 ? 8'h10 : 8'h00);
            end
            default: begin
                s = bus_op(1'b1, 'h4000, 'hBFFF);
            end
        endcase
        return s;
    endfunction

    function automatic stim_t random_access(input mapper_t m);
        int r;
        r = rand_below(10);
        if (r < 3) begin
            return reg_write(m);
        end else if (r < 5) begin
            return bus_op(1'b1, 'h4000, 'hBFFF);
        end else if (r < 9) begin
            return bus_op(1'b0, 'h4000, 'hBFFF);
        end
        return bus_op(1'b0, 'h0000, 'hFFFF);      // Also outside the banked window
    endfunction

    task automatic drive_bus(input stim_t s);
        {en, clk_en, mreq, rd, wr, addr, d_from_cpu} = s;
        cfg = cur_cfg;
    endtask

    // Called at a rising edge, returns at the next one
    task automatic run_cycle(input stim_t s);
        mem_out_t want;
        #2;
        drive_bus(s);
        #(CLK_PERIOD - 4);
        want = expected_outputs(cur_cfg, s);
        if ({mem_addr, mem_rd, sram_oe, sram_we} !== want) begin
            fail_count++;
            test_errors++;
            $display("[ERROR] %0t: addr %h rd %b wr %b, got %h/%b/%b/%b, expected %h/%b/%b/%b",
                     $time, s.addr, s.rd, s.wr, mem_addr, mem_rd, sram_oe, sram_we,
                     want.addr, want.rd, want.oe, want.we);
        end else begin
            pass_count++;
        end
        test_cycles++;
        @(posedge clk);
        update_model_banks(cur_cfg, s);
    endtask

    task automatic end_test(input string name);
        $display("Test %0d %s: %0d cycles, %0d errors, %s", test_num, name, test_cycles,
                 test_errors, test_errors == 0 ? "ok" : "FAIL");
        test_num++;
        test_errors = 0;
        test_cycles = 0;
    endtask

    task automatic check_reset_banks();
        for (int m = 0; m < 4; m++) begin
            cur_cfg.mapper       = mapper_t'(m);
            cur_cfg.rom_size_log = (m == 0) ? 4'd2 : 4'd8;
            for (int p = 0; p < 8; p++) begin
                run_cycle(bus_op(1'b0, 'h4000 + (p / 2) * 'h2000, 'h5FFF + (p / 2) * 'h2000));
            end
        end
        end_test("reset banks");
    endtask

    task automatic banked_traffic(input mapper_t m, input string name);
        cur_cfg.mapper = m;
        for (int b = 0; b < 3; b++) begin
            cur_cfg.rom_size_log = 4'(rand_below(9));
            for (int i = 0; i < BLOCK_LEN; i++) begin
                run_cycle(random_access(m));
            end
        end
        end_test(name);
    endtask

    task automatic linear_mirroring();
        cur_cfg.mapper = MAPPER_LINEAR;
        for (int size = 0; size < 4; size++) begin
            cur_cfg.rom_size_log = 4'(size);
            for (int i = 0; i < 16; i++) begin
                run_cycle(bus_op(rand_below(8) == 0, 'h0000, 'hFFFF));
            end
        end
        end_test("linear");
    endtask

    task automatic gated_accesses();
        stim_t s;
        for (int m = 1; m < 4; m++) begin
            cur_cfg.mapper       = mapper_t'(m);
            cur_cfg.rom_size_log = 4'd8;
            for (int i = 0; i < 24; i++) begin
                if (rand_below(2) == 0) begin
                    s = reg_write(mapper_t'(m));
                end else begin
                    s = random_access(mapper_t'(m)); // Reads and SRAM page writes too
                end
                case (rand_below(3))
                    0: s.en = 1'b0;
                    1: s.mreq = 1'b0;
                    default: s.clk_en = 1'b0;
                endcase
                run_cycle(s);
            end
            for (int p = 0; p < 8; p++) begin
                run_cycle(bus_op(1'b0, 'h4000 + p * 'h1000, 'h4FFF + p * 'h1000));
            end
        end
        end_test("gated accesses");
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not end within %0d time units", WATCHDOG_TIME);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed        = 22;
        clk         = 1'b0;
        reset       = 1'b1;
        cur_cfg     = '0;
        test_num    = 1;
        test_errors = 0;
        test_cycles = 0;
        pass_count  = 0;
        fail_count  = 0;
        drive_bus('0);
        reset_model_banks();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        check_reset_banks();
        banked_traffic(MAPPER_KONAMI, "konami");
        banked_traffic(MAPPER_ASCII8, "ascii8");
        banked_traffic(MAPPER_ASCII16, "ascii16");
        linear_mirroring();
        gated_accesses();
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verif
source/msx_cart_pkg.sv
source/cart_mapper_decoder.sv
source/cart_konami.sv
source/cart_ascii8.sv
source/cart_ascii16.sv
source/cart_linear.sv
source/cart_mem_arbiter.sv
source/cart_rom.sv
verif/cart_rom_tb.sv
